// ==== include/alu_params.svh ====
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

// operand and result width of the datapath
`define DATA_WIDTH 32

// the 5-bit register fields of the instruction fix the register file geometry
`define REG_COUNT 32
`define REG_ADDR_WIDTH 5

// the immediate is the low field of the instruction word and is sign-extended to DATA_WIDTH
`define IMM_WIDTH 12

`endif

// ==== logic/alu_pkg.sv ====
package alu_pkg;

   // command encoding of the 3-bit ALU select
   typedef enum logic [2:0] {
      cmdAdd  = 3'd0,
      cmdSub  = 3'd1,
      cmdXor  = 3'd2,
      cmdSlt  = 3'd3,
      cmdAnd  = 3'd4,
      cmdNand = 3'd5,
      cmdNor  = 3'd6,
      cmdOr   = 3'd7
   } aluCmd;

   // top two bits of the instruction word
   typedef enum logic [1:0] {
      opNop = 2'd0,
      opReg = 2'd1,
      opImm = 2'd2,
      opBad = 2'd3
   } instrOp;

endpackage

// ==== logic/exec_if.sv ====
`timescale 1ns/1ps

`include "alu_params.svh"

interface execCtrl;
   import alu_pkg::*;

   aluCmd                     cmd;
   logic [`REG_ADDR_WIDTH-1:0] rd;
   logic [`REG_ADDR_WIDTH-1:0] rs;
   logic [`REG_ADDR_WIDTH-1:0] rt;
   logic                      useImm;
   logic [`DATA_WIDTH-1:0]    immValue;
   logic                      writeEn;

   modport decoder (
      output cmd, rd, rs, rt, useImm, immValue, writeEn
   );

   modport datapath (
      input cmd, rd, rs, rt, useImm, immValue, writeEn
   );

endinterface

// ==== logic/alu.sv ====
`timescale 1ns/1ps

`include "alu_params.svh"

module alu (
   input  logic [`DATA_WIDTH-1:0] operandA,
   input  logic [`DATA_WIDTH-1:0] operandB,
   input  alu_pkg::aluCmd         command,
   output logic [`DATA_WIDTH-1:0] result,
   output logic                   carryout,
   output logic                   overflow,
   output logic                   zero
);
   import alu_pkg::*;

   logic                   doSub;
   logic [`DATA_WIDTH-1:0] operandBAdj;
   logic [`DATA_WIDTH-1:0] sum;
   logic [`DATA_WIDTH:0]   carry;
   logic                   sumOverflow;
   logic                   lessThan;

   // subtract and set-less-than share one chain that computes A + ~B + 1
   assign doSub = command inside {cmdSub, cmdSlt};
   assign operandBAdj = doSub ? ~operandB : operandB;

   always_comb begin
      carry[0] = doSub;
      for (int i = 0; i < `DATA_WIDTH; i++) begin
         sum[i] = operandA[i] ^ operandBAdj[i] ^ carry[i];
         carry[i+1] = (operandA[i] & operandBAdj[i]) |
                      ((operandA[i] ^ operandBAdj[i]) & carry[i]);
      end
      // the ripple chain must agree with the plain sum of its inputs
      assert ({carry[`DATA_WIDTH], sum} == {1'b0, operandA} + {1'b0, operandBAdj} + doSub)
         else $error("alu: ripple sum disagrees with the adder inputs");
   end

   // carries into and out of the sign bit disagree on signed overflow
   assign sumOverflow = carry[`DATA_WIDTH] ^ carry[`DATA_WIDTH-1];

   // sign of the difference is wrong exactly when the subtraction overflowed
   assign lessThan = sum[`DATA_WIDTH-1] ^ sumOverflow;

   always_comb begin
      result = '0;
      carryout = 1'b0;
      overflow = 1'b0;
      case (command)
         cmdAdd, cmdSub: begin
            result = sum;
            carryout = carry[`DATA_WIDTH];
            overflow = sumOverflow;
         end
         cmdXor: begin
            result = operandA ^ operandB;
         end
         cmdSlt: begin
            result = {`DATA_WIDTH{lessThan}};
         end
         cmdAnd: begin
            result = operandA & operandB;
         end
         cmdNand: begin
            result = ~(operandA & operandB);
         end
         cmdNor: begin
            result = ~(operandA | operandB);
         end
         cmdOr: begin
            result = operandA | operandB;
         end
         default: begin
            result = '0;
         end
      endcase
   end

   assign zero = ~|result;

endmodule

// ==== logic/instr_decoder.sv ====
`timescale 1ns/1ps

`include "alu_params.svh"

module instr_decoder (
   input  logic                   instrValid,
   input  logic [`DATA_WIDTH-1:0] instr,
   execCtrl.decoder               ctrl,
   output logic                   illegal
);
   import alu_pkg::*;

   instrOp                 op;
   logic [`IMM_WIDTH-1:0]  immField;

   // the fixed word layout runs op, cmd, rd, rs, rt and immediate from the top down
   assign op = instrOp'(instr[31:30]);
   assign immField = instr[`IMM_WIDTH-1:0];

   always_comb begin
      ctrl.cmd = aluCmd'(instr[29:27]);
      ctrl.rd = instr[26:22];
      ctrl.rs = instr[21:17];
      ctrl.rt = instr[16:12];
      ctrl.immValue = {{(`DATA_WIDTH-`IMM_WIDTH){immField[`IMM_WIDTH-1]}}, immField};
      ctrl.useImm = 1'b0;
      ctrl.writeEn = 1'b0;
      illegal = 1'b0;
      case (op)
         opReg: begin
            ctrl.writeEn = instrValid;
         end
         opImm: begin
            ctrl.useImm = 1'b1;
            ctrl.writeEn = instrValid;
         end
         opBad: begin
            illegal = instrValid;
         end
         opNop: begin
            ctrl.writeEn = 1'b0;
         end
         default: begin
            ctrl.writeEn = 1'b0;
         end
      endcase
   end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps

`include "alu_params.svh"

module reg_file (
   input  logic                       clk,
   input  logic                       rstN,
   input  logic [`REG_ADDR_WIDTH-1:0] readAddrA,
   input  logic [`REG_ADDR_WIDTH-1:0] readAddrB,
   output logic [`DATA_WIDTH-1:0]     readDataA,
   output logic [`DATA_WIDTH-1:0]     readDataB,
   input  logic                       writeEn,
   input  logic [`REG_ADDR_WIDTH-1:0] writeAddr,
   input  logic [`DATA_WIDTH-1:0]     writeData
);

   logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

   // register 0 is never written, so it holds the zero loaded at reset
   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEn && (writeAddr != '0)) begin
         regs[writeAddr] <= writeData;
      end
   end

   assign readDataA = regs[readAddrA];
   assign readDataB = regs[readAddrB];

   // a write must carry a known address and known data
   assertKnownWrite: assert property (
      @(posedge clk) disable iff (!rstN) writeEn |-> !$isunknown({writeAddr, writeData})
   ) else $error("reg_file: write with unknown address or data");

endmodule

// ==== logic/exec_unit.sv ====
`timescale 1ns/1ps

`include "alu_params.svh"

module exec_unit (
   input  logic                   clk,
   input  logic                   rstN,
   input  logic                   instrValid,
   input  logic [`DATA_WIDTH-1:0] instr,
   output logic                   resultValid,
   output logic [`DATA_WIDTH-1:0] result,
   output logic                   zero,
   output logic                   carryout,
   output logic                   overflow,
   output logic                   illegal
);

   execCtrl ctrl ();

   logic                   decodeIllegal;
   logic [`DATA_WIDTH-1:0] readDataA;
   logic [`DATA_WIDTH-1:0] readDataB;
   logic [`DATA_WIDTH-1:0] operandB;
   logic [`DATA_WIDTH-1:0] aluResult;
   logic                   aluZero;
   logic                   aluCarryout;
   logic                   aluOverflow;

   instr_decoder uDecoder (
      .instrValid (instrValid),
      .instr      (instr),
      .ctrl       (ctrl.decoder),
      .illegal    (decodeIllegal)
   );

   // the write lands on the same edge that samples the instruction
   reg_file uRegFile (
      .clk       (clk),
      .rstN      (rstN),
      .readAddrA (ctrl.rs),
      .readAddrB (ctrl.rt),
      .readDataA (readDataA),
      .readDataB (readDataB),
      .writeEn   (ctrl.writeEn),
      .writeAddr (ctrl.rd),
      .writeData (aluResult)
   );

   assign operandB = ctrl.useImm ? ctrl.immValue : readDataB;

   alu uAlu (
      .operandA (readDataA),
      .operandB (operandB),
      .command  (ctrl.cmd),
      .result   (aluResult),
      .carryout (aluCarryout),
      .overflow (aluOverflow),
      .zero     (aluZero)
   );

   always_ff @(posedge clk) begin
      if (!rstN) begin
         resultValid <= 1'b0;
         illegal <= 1'b0;
         result <= '0;
         zero <= 1'b0;
         carryout <= 1'b0;
         overflow <= 1'b0;
      end else begin
         resultValid <= ctrl.writeEn;
         illegal <= decodeIllegal;
         // outputs hold the last result between pulses
         if (ctrl.writeEn) begin
            result <= aluResult;
            zero <= aluZero;
            carryout <= aluCarryout;
            overflow <= aluOverflow;
         end
      end
   end

endmodule

// ==== test/tb_exec_unit.sv ====
`timescale 1ns/1ps

`include "alu_params.svh"

module tb_exec_unit;

   localparam int clkPeriod = 100;
   localparam int resetCycles = 10;
   localparam int numAddSub = 40;
   localparam int numRandom = 300;
   // reset, directed section, five 25-instruction constant loads, random sections, margin
   localparam int maxCycles = resetCycles + 60 + 5 * 25 + numAddSub + numRandom + 165;
   localparam int msb = `DATA_WIDTH - 1;

   // instruction word layout
   localparam int opLsb = 30;
   localparam int cmdLsb = 27;
   localparam int rdLsb = 22;
   localparam int rsLsb = 17;
   localparam int rtLsb = 12;
   localparam int immWidth = 12;

   localparam logic [1:0] nopOp = 2'd0;
   localparam logic [1:0] regOp = 2'd1;
   localparam logic [1:0] immOp = 2'd2;
   localparam logic [1:0] badOp = 2'd3;

   localparam logic [2:0] addCmd = 3'd0;
   localparam logic [2:0] subCmd = 3'd1;
   localparam logic [2:0] xorCmd = 3'd2;
   localparam logic [2:0] sltCmd = 3'd3;
   localparam logic [2:0] andCmd = 3'd4;
   localparam logic [2:0] nandCmd = 3'd5;
   localparam logic [2:0] norCmd = 3'd6;
   localparam logic [2:0] orCmd = 3'd7;

   logic                   clk;
   logic                   rstN;
   logic                   instrValid;
   logic [`DATA_WIDTH-1:0] instr;
   logic                   resultValid;
   logic [`DATA_WIDTH-1:0] result;
   logic                   zero;
   logic                   carryout;
   logic                   overflow;
   logic                   illegal;

   logic [`DATA_WIDTH-1:0] shadowRegs [`REG_COUNT];
   logic                   expValid = 1'b0;
   logic                   expIllegal = 1'b0;
   logic [`DATA_WIDTH-1:0] expResult = '0;
   logic                   expZero = 1'b0;
   logic                   expCarry = 1'b0;
   logic                   expOverflow = 1'b0;
   int                     errorCount = 0;
   int                     checkCount = 0;

   exec_unit u_dut (
      .clk         (clk),
      .rstN        (rstN),
      .instrValid  (instrValid),
      .instr       (instr),
      .resultValid (resultValid),
      .result      (result),
      .zero        (zero),
      .carryout    (carryout),
      .overflow    (overflow),
      .illegal     (illegal)
   );

   always #(clkPeriod / 2) clk = ~clk;

   function automatic void aluRef(
      input  logic [2:0]      cmd,
      input  logic [msb:0]    a,
      input  logic [msb:0]    b,
      output logic [msb:0]    res,
      output logic            co,
      output logic            ov,
      output logic            z
   );
      logic [msb+1:0] wide;
      wide = '0;
      res = '0;
      co = 1'b0;
      ov = 1'b0;
      case (cmd)
         addCmd: begin
            wide = {1'b0, a} + {1'b0, b};
            res = wide[msb:0];
            co = wide[msb+1];
            // like-signed operands whose sum flips sign
            ov = (a[msb] == b[msb]) && (res[msb] != a[msb]);
         end
         subCmd: begin
            wide = {1'b0, a} + {1'b0, ~b} + 1;
            res = wide[msb:0];
            co = wide[msb+1];
            ov = (a[msb] != b[msb]) && (res[msb] != a[msb]);
         end
         xorCmd: res = a ^ b;
         sltCmd: res = ($signed(a) < $signed(b)) ? '1 : '0;
         andCmd: res = a & b;
         nandCmd: res = ~(a & b);
         norCmd: res = ~(a | b);
         orCmd: res = a | b;
         default: res = '0;
      endcase
      z = (res == '0);
   endfunction

   function automatic logic [msb:0] buildInstr(
      input logic [1:0] op,
      input logic [2:0] cmd,
      input logic [4:0] rd,
      input logic [4:0] rs,
      input logic [4:0] rt,
      input logic [immWidth-1:0] imm
   );
      return {op, cmd, rd, rs, rt, imm};
   endfunction

   // the model of the DUT state steps at the edge that samples each instruction
   always @(posedge clk) begin : model
      logic [1:0]   op;
      logic [2:0]   cmd;
      logic [4:0]   rd;
      logic [msb:0] opA;
      logic [msb:0] opB;
      logic [msb:0] res;
      logic         co;
      logic         ov;
      logic         z;
      op = instr[opLsb +: 2];
      cmd = instr[cmdLsb +: 3];
      rd = instr[rdLsb +: 5];
      if (!rstN) begin
         for (int i = 0; i < `REG_COUNT; i++) begin
            shadowRegs[i] <= '0;
         end
         expValid <= 1'b0;
         expIllegal <= 1'b0;
         expResult <= '0;
         expZero <= 1'b0;
         expCarry <= 1'b0;
         expOverflow <= 1'b0;
      end else begin
         expValid <= 1'b0;
         expIllegal <= instrValid && (op == badOp);
         if (instrValid && (op == regOp || op == immOp)) begin
            opA = shadowRegs[instr[rsLsb +: 5]];
            if (op == immOp)
               opB = {{(`DATA_WIDTH - immWidth){instr[immWidth-1]}}, instr[immWidth-1:0]};
            else
               opB = shadowRegs[instr[rtLsb +: 5]];
            aluRef(cmd, opA, opB, res, co, ov, z);
            expValid <= 1'b1;
            expResult <= res;
            expZero <= z;
            expCarry <= co;
            expOverflow <= ov;
            if (rd != 5'd0) begin
               shadowRegs[rd] <= res;
            end
         end
      end
   end

   task automatic reportMismatch(input string name, input logic [msb:0] expValue,
                                 input logic [msb:0] gotValue);
      $display("ERROR time=%0t signal=%s expected=%h actual=%h", $time, name, expValue, gotValue);
      errorCount++;
   endtask

   // outputs settle after the rising edge, so compare them at the falling edge
   always @(negedge clk) begin
      checkCount++;
      if (resultValid !== expValid)
         reportMismatch("resultValid", 32'(expValid), 32'(resultValid));
      if (illegal !== expIllegal)
         reportMismatch("illegal", 32'(expIllegal), 32'(illegal));
      if (expValid) begin
         if (result !== expResult)
            reportMismatch("result", expResult, result);
         if (zero !== expZero)
            reportMismatch("zero", 32'(expZero), 32'(zero));
         if (carryout !== expCarry)
            reportMismatch("carryout", 32'(expCarry), 32'(carryout));
         if (overflow !== expOverflow)
            reportMismatch("overflow", 32'(expOverflow), 32'(overflow));
      end
   end

   task automatic driveWord(input logic valid, input logic [msb:0] word);
      @(negedge clk);
      instrValid = valid;
      instr = word;
   endtask

   task automatic issue(input logic [1:0] op, input logic [2:0] cmd, input logic [4:0] rd,
                        input logic [4:0] rs, input logic [4:0] rt,
                        input logic [immWidth-1:0] imm);
      driveWord(1'b1, buildInstr(op, cmd, rd, rs, rt, imm));
   endtask

   task automatic idle(input int cycles);
      repeat (cycles) driveWord(1'b0, '0);
   endtask

   // no shift command, so build a 32-bit constant by doubling and or-ing 11-bit chunks
   task automatic loadConst(input logic [4:0] rd, input logic [msb:0] value);
      issue(immOp, orCmd, rd, 5'd0, 5'd0, {2'b00, value[31:22]});
      repeat (11) issue(regOp, addCmd, rd, rd, rd, 12'd0);
      issue(immOp, orCmd, rd, rd, 5'd0, {1'b0, value[21:11]});
      repeat (11) issue(regOp, addCmd, rd, rd, rd, 12'd0);
      issue(immOp, orCmd, rd, rd, 5'd0, {1'b0, value[10:0]});
   endtask

   task automatic runAddSub(input int count);
      logic [2:0] cmd;
      for (int i = 0; i < count; i++) begin
         cmd = ($urandom_range(0, 1) == 0) ? addCmd : subCmd;
         issue(regOp, cmd, 5'(20 + $urandom_range(0, 11)), 5'(16 + $urandom_range(0, 3)),
               5'(16 + $urandom_range(0, 3)), 12'd0);
      end
   endtask

   task automatic runRandom(input int count);
      int         sel;
      logic       valid;
      logic [1:0] op;
      for (int i = 0; i < count; i++) begin
         sel = int'($urandom_range(0, 9));
         if (sel == 0)
            op = nopOp;
         else if (sel == 1)
            op = badOp;
         else if (sel < 6)
            op = regOp;
         else
            op = immOp;
         valid = ($urandom_range(0, 7) != 0);
         driveWord(valid, buildInstr(op, 3'($urandom_range(0, 7)), 5'($urandom_range(0, 31)),
                   5'($urandom_range(0, 31)), 5'($urandom_range(0, 31)),
                   12'($urandom_range(0, 4095))));
      end
   endtask

   initial begin
      void'($urandom(38));
      clk = 1'b0;
      rstN = 1'b0;
      instrValid = 1'b0;
      instr = '0;
      repeat (resetCycles) @(negedge clk);
      rstN = 1'b1;
      idle(3);
      issue(regOp, addCmd, 5'd20, 5'd5, 5'd6, 12'd0);
      issue(immOp, subCmd, 5'd21, 5'd9, 5'd0, 12'd0);

      // r1 holds max positive, r2 one and r4 minus one for the add and subtract edges
      loadConst(5'd1, 32'h7FFF_FFFF);
      issue(immOp, addCmd, 5'd2, 5'd0, 5'd0, 12'd1);
      issue(regOp, addCmd, 5'd3, 5'd1, 5'd2, 12'd0);
      issue(regOp, subCmd, 5'd4, 5'd0, 5'd2, 12'd0);
      issue(regOp, subCmd, 5'd5, 5'd1, 5'd1, 12'd0);
      issue(regOp, addCmd, 5'd6, 5'd4, 5'd2, 12'd0);
      issue(regOp, subCmd, 5'd7, 5'd3, 5'd2, 12'd0);

      // in the set-less-than cases the first two overflow in the subtraction
      issue(regOp, sltCmd, 5'd8, 5'd3, 5'd2, 12'd0);
      issue(regOp, sltCmd, 5'd8, 5'd1, 5'd4, 12'd0);
      issue(regOp, sltCmd, 5'd8, 5'd4, 5'd2, 12'd0);
      issue(regOp, sltCmd, 5'd8, 5'd2, 5'd4, 12'd0);
      issue(regOp, sltCmd, 5'd8, 5'd1, 5'd1, 12'd0);

      for (int c = 2; c < 8; c++) begin
         issue(regOp, 3'(c), 5'd9, 5'd1, 5'd4, 12'd0);
         issue(regOp, 3'(c), 5'd9, 5'd3, 5'd2, 12'd0);
         issue(immOp, 3'(c), 5'd10, 5'd1, 5'd0, 12'hF0F);
      end

      // immediates, a dependent chain and writes aimed at register 0
      issue(immOp, addCmd, 5'd11, 5'd0, 5'd0, 12'h800);
      issue(immOp, addCmd, 5'd11, 5'd11, 5'd0, 12'h7FF);
      issue(regOp, addCmd, 5'd12, 5'd11, 5'd11, 12'd0);
      issue(immOp, addCmd, 5'd0, 5'd1, 5'd0, 12'h123);
      issue(regOp, orCmd, 5'd13, 5'd0, 5'd0, 12'd0);
      issue(regOp, addCmd, 5'd13, 5'd0, 5'd1, 12'd0);

      // neither nop nor a bad opcode may touch r1
      issue(nopOp, addCmd, 5'd1, 5'd2, 5'd2, 12'd0);
      issue(badOp, addCmd, 5'd1, 5'd2, 5'd2, 12'd0);
      issue(regOp, orCmd, 5'd15, 5'd1, 5'd0, 12'd0);
      idle(2);

      for (int k = 0; k < 4; k++) begin
         loadConst(5'(16 + k), $urandom());
      end
      runAddSub(numAddSub);
      runRandom(numRandom);
      idle(3);

      $display("checks: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

   initial begin
      #(maxCycles * clkPeriod);
      $display("timeout: the run did not finish within %0d clock cycles", maxCycles);
      $display("checks: %0d, errors: %0d", checkCount, errorCount);
      $display("test failed");
      $finish;
   end

endmodule

// ==== tb.f ====
+incdir+include
logic/alu_pkg.sv
logic/exec_if.sv
logic/alu.sv
logic/instr_decoder.sv
logic/reg_file.sv
logic/exec_unit.sv
test/tb_exec_unit.sv

// ==== Makefile ====
TOP = tb_exec_unit
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f tb.f --top-module $(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "test passed" $(LOG) && echo "simulation PASS" || (echo "simulation FAIL"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
